//--- mvt_pkg.sv
`default_nettype none

package mvt_pkg;

    // ####################################################################
    // data path
    // ####################################################################

    // one matrix or vector element
    typedef logic [31:0] word_t;

    // ####################################################################
    // load port select
    // ####################################################################

    // codes below the partition factor pick an A bank
    localparam int MEM_SEL_W = 4;

    localparam logic [MEM_SEL_W-1:0] SEL_X1 = 4'd12;
    localparam logic [MEM_SEL_W-1:0] SEL_X2 = 4'd13;
    localparam logic [MEM_SEL_W-1:0] SEL_Y1 = 4'd14;
    localparam logic [MEM_SEL_W-1:0] SEL_Y2 = 4'd15;

    // ####################################################################
    // output signature
    // ####################################################################

    localparam int FOLD_W = 4;

endpackage

`default_nettype wire

//--- mvt_out_if.sv
`timescale 1ns/1ps
`default_nettype none

// result streams from the core to the output fold
interface mvt_out_if
    import mvt_pkg::*;
();

    word_t x1_out_din;
    logic  x1_out_write;
    word_t x2_out_din;
    logic  x2_out_write;

    // core side
    modport producer (
        output x1_out_din,
        output x1_out_write,
        output x2_out_din,
        output x2_out_write
    );

    // fold side, no back-pressure
    modport consumer (
        input x1_out_din,
        input x1_out_write,
        input x2_out_din,
        input x2_out_write
    );

endinterface

`default_nettype wire

//--- kernel_ram.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_ram
    import mvt_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
)
(
    input  logic          ap_clk,
    input  logic          rst,

    // load side
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  word_t         wdata,

    // kernel read side
    input  logic          en,
    input  logic [AW-1:0] addr,
    output word_t         dout
);

    // storage, contents survive reset
    word_t mem [DEPTH];

    // ####################################################################
    // write port
    // ####################################################################

    always_ff @(posedge ap_clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // ####################################################################
    // registered read port
    // ####################################################################

    // data shows up one cycle after en
    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            dout <= '0;
        end
        else if (en)
        begin
            dout <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- mvt_core.sv
`timescale 1ns/1ps
`default_nettype none

module mvt_core
    import mvt_pkg::*;
#(
    parameter int MATRIX_DIM = 4,
    parameter int PARTITION_FACTOR = 2,
    localparam int BANK_DEPTH = MATRIX_DIM * MATRIX_DIM / PARTITION_FACTOR,
    localparam int BANK_AW = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1,
    localparam int VEC_AW = (MATRIX_DIM > 1) ? $clog2(MATRIX_DIM) : 1
)
(
    input  logic                        ap_clk,
    input  logic                        rst,
    input  logic                        ap_start,
    output logic                        ap_done,
    output logic                        ap_idle,

    output logic [PARTITION_FACTOR-1:0] a_en,
    output logic [BANK_AW-1:0]          a_addr,
    input  word_t                       a_dout [PARTITION_FACTOR],

    output logic                        x1_en,
    output logic [VEC_AW-1:0]           x1_addr,
    input  word_t                       x1_dout,
    output logic                        x2_en,
    output logic [VEC_AW-1:0]           x2_addr,
    input  word_t                       x2_dout,
    output logic                        y1_en,
    output logic [VEC_AW-1:0]           y1_addr,
    input  word_t                       y1_dout,
    output logic                        y2_en,
    output logic [VEC_AW-1:0]           y2_addr,
    input  word_t                       y2_dout,

    mvt_out_if.producer                 res
);

    // step counts one past the last column for the drain cycle
    localparam int CNT_W = $clog2(MATRIX_DIM + 1);
    localparam int BSW = (PARTITION_FACTOR > 1) ? $clog2(PARTITION_FACTOR) : 1;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_PH_X1 = 2'd1;
    localparam logic [1:0] S_PH_X2 = 2'd2;
    localparam logic [1:0] S_DONE  = 2'd3;

    logic [1:0]        state;
    logic [VEC_AW-1:0] idx;
    logic [CNT_W-1:0]  step;
    logic              busy;
    logic              issue;
    logic              step_end;
    logic              idx_end;
    logic [CNT_W-1:0]  row;
    logic [CNT_W-1:0]  col;
    logic [BSW-1:0]    bank_idx;

    // read pipeline one stage behind the issue
    logic              rd_valid;
    logic              rd_first;
    logic              rd_last;
    logic              rd_x2;
    logic [BSW-1:0]    bank_q;
    word_t             acc;
    word_t             acc_next;
    word_t             x1_res_q;
    word_t             x2_res_q;
    logic              x1_wr_q;
    logic              x2_wr_q;

    // ####################################################################
    // control FSM and counters
    // ####################################################################

    assign busy     = (state == S_PH_X1) || (state == S_PH_X2);
    assign step_end = (step == CNT_W'(MATRIX_DIM));
    assign idx_end  = (idx == VEC_AW'(MATRIX_DIM - 1));
    assign issue    = busy && !step_end;

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            idx   <= '0;
            step  <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    idx  <= '0;
                    step <= '0;
                    if (ap_start)
                    begin
                        state <= S_PH_X1;
                    end
                end
                S_PH_X1, S_PH_X2:
                begin
                    if (!step_end)
                    begin
                        step <= step + 1'b1;
                    end
                    else
                    begin
                        step <= '0;
                        if (idx_end)
                        begin
                            idx   <= '0;
                            state <= (state == S_PH_X1) ? S_PH_X2 : S_DONE;
                        end
                        else
                        begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // done lines up with the final x2 strobe
    assign ap_done = (state == S_DONE);
    assign ap_idle = (state == S_IDLE);

    // ####################################################################
    // address generation
    // ####################################################################

    // x1 walks a row and x2 walks a column
    assign row = (state == S_PH_X2) ? step : CNT_W'(idx);
    assign col = (state == S_PH_X2) ? CNT_W'(idx) : step;

    assign bank_idx = BSW'(row % PARTITION_FACTOR);
    assign a_addr   = BANK_AW'((row / PARTITION_FACTOR) * MATRIX_DIM + col);

    always_comb
    begin
        a_en = '0;
        if (issue)
        begin
            a_en[bank_idx] = 1'b1;
        end
    end

    // x seeds the sum and is read with the first element
    assign x1_en   = issue && (state == S_PH_X1) && (step == '0);
    assign x1_addr = idx;
    assign x2_en   = issue && (state == S_PH_X2) && (step == '0);
    assign x2_addr = idx;
    assign y1_en   = issue && (state == S_PH_X1);
    assign y1_addr = VEC_AW'(col);
    assign y2_en   = issue && (state == S_PH_X2);
    assign y2_addr = VEC_AW'(row);

    // ####################################################################
    // multiply-accumulate
    // ####################################################################

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            rd_valid <= 1'b0;
            rd_first <= 1'b0;
            rd_last  <= 1'b0;
            rd_x2    <= 1'b0;
            bank_q   <= '0;
        end
        else
        begin
            rd_valid <= issue;
            rd_first <= issue && (step == '0);
            rd_last  <= issue && (step == CNT_W'(MATRIX_DIM - 1));
            rd_x2    <= (state == S_PH_X2);
            bank_q   <= bank_idx;
        end
    end

    // wraps modulo 2^32
    always_comb
    begin
        acc_next = rd_x2 ? a_dout[bank_q] * y2_dout : a_dout[bank_q] * y1_dout;
        if (rd_first)
        begin
            acc_next = acc_next + (rd_x2 ? x2_dout : x1_dout);
        end
        else
        begin
            acc_next = acc_next + acc;
        end
    end

    // each stream holds its own last result
    always_ff @(posedge ap_clk)
    begin
        if (rd_valid)
        begin
            acc <= acc_next;
        end
        if (rd_valid && rd_last && !rd_x2)
        begin
            x1_res_q <= acc_next;
        end
        if (rd_valid && rd_last && rd_x2)
        begin
            x2_res_q <= acc_next;
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            x1_wr_q <= 1'b0;
            x2_wr_q <= 1'b0;
        end
        else
        begin
            x1_wr_q <= rd_valid && rd_last && !rd_x2;
            x2_wr_q <= rd_valid && rd_last && rd_x2;
        end
    end

    assign res.x1_out_din   = x1_res_q;
    assign res.x1_out_write = x1_wr_q;
    assign res.x2_out_din   = x2_res_q;
    assign res.x2_out_write = x2_wr_q;

endmodule

`default_nettype wire

//--- xor_fold.sv
`timescale 1ns/1ps
`default_nettype none

module xor_fold
    import mvt_pkg::*;
(
    input  logic              ap_clk,
    input  logic              rst,
    mvt_out_if.consumer       res,
    output logic [FOLD_W-1:0] data_out,
    output logic              data_valid
);

    logic [7:0] x1_byte;
    logic [7:0] x2_byte;
    logic       x1_v1;
    logic       x2_v1;
    logic [7:0] mix;
    logic       v2;

    // ####################################################################
    // stage 1: bytes of each word
    // ####################################################################

    always_ff @(posedge ap_clk)
    begin
        x1_byte <= res.x1_out_din[7:0] ^ res.x1_out_din[15:8]
                 ^ res.x1_out_din[23:16] ^ res.x1_out_din[31:24];
        x2_byte <= res.x2_out_din[7:0] ^ res.x2_out_din[15:8]
                 ^ res.x2_out_din[23:16] ^ res.x2_out_din[31:24];
    end

    // ####################################################################
    // stage 2: pick the live stream
    // ####################################################################

    // both live would be xored, core never does that
    always_ff @(posedge ap_clk)
    begin
        case ({x1_v1, x2_v1})
            2'b10:   mix <= x1_byte;
            2'b01:   mix <= x2_byte;
            2'b11:   mix <= x1_byte ^ x2_byte;
            default: mix <= '0;
        endcase
    end

    // ####################################################################
    // stage 3: nibble fold
    // ####################################################################

    always_ff @(posedge ap_clk)
    begin
        data_out <= mix[7:4] ^ mix[3:0];
    end

    // valid pipe, three cycles behind the strobes
    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            x1_v1      <= 1'b0;
            x2_v1      <= 1'b0;
            v2         <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            x1_v1      <= res.x1_out_write;
            x2_v1      <= res.x2_out_write;
            v2         <= x1_v1 | x2_v1;
            data_valid <= v2;
        end
    end

endmodule

`default_nettype wire

//--- mvt_top.sv
`timescale 1ns/1ps
`default_nettype none

module mvt_top
    import mvt_pkg::*;
#(
    parameter int MATRIX_DIM = 4,
    parameter int PARTITION_FACTOR = 2,
    localparam int BANK_DEPTH = MATRIX_DIM * MATRIX_DIM / PARTITION_FACTOR,
    localparam int BANK_AW = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1,
    localparam int VEC_AW = (MATRIX_DIM > 1) ? $clog2(MATRIX_DIM) : 1
)
(
    input  logic                 ap_clk,
    input  logic                 rst,
    input  logic                 ap_start,
    output logic                 ap_done,
    output logic                 ap_idle,

    // memory load port, honoured only while idle
    input  logic                 load_we,
    input  logic [MEM_SEL_W-1:0] load_sel,
    input  logic [BANK_AW-1:0]   load_addr,
    input  word_t                load_data,

    output logic [FOLD_W-1:0]    data_out,
    output logic                 data_valid
);

    logic                        load_ok;
    logic [PARTITION_FACTOR-1:0] a_we;
    logic [PARTITION_FACTOR-1:0] a_en;
    logic [BANK_AW-1:0]          a_addr;
    word_t                       a_dout [PARTITION_FACTOR];
    logic                        x1_en;
    logic [VEC_AW-1:0]           x1_addr;
    word_t                       x1_dout;
    logic                        x2_en;
    logic [VEC_AW-1:0]           x2_addr;
    word_t                       x2_dout;
    logic                        y1_en;
    logic [VEC_AW-1:0]           y1_addr;
    word_t                       y1_dout;
    logic                        y2_en;
    logic [VEC_AW-1:0]           y2_addr;
    word_t                       y2_dout;

    mvt_out_if res_if ();

    assign load_ok = load_we && ap_idle;

    // ####################################################################
    // A banks, row r lives in bank r mod PARTITION_FACTOR
    // ####################################################################

    for (genvar b = 0; b < PARTITION_FACTOR; b++)
    begin : g_a_bank
        assign a_we[b] = load_ok && (load_sel == MEM_SEL_W'(b));

        kernel_ram #(.DEPTH(BANK_DEPTH)) i_a_ram (
            .ap_clk (ap_clk),
            .rst    (rst),
            .we     (a_we[b]),
            .waddr  (load_addr),
            .wdata  (load_data),
            .en     (a_en[b]),
            .addr   (a_addr),
            .dout   (a_dout[b])
        );
    end

    // ####################################################################
    // vector RAMs
    // ####################################################################

    kernel_ram #(.DEPTH(MATRIX_DIM)) i_x1_ram (
        .ap_clk (ap_clk), .rst (rst),
        .we     (load_ok && (load_sel == SEL_X1)),
        .waddr  (load_addr[VEC_AW-1:0]), .wdata (load_data),
        .en     (x1_en), .addr (x1_addr), .dout (x1_dout)
    );

    kernel_ram #(.DEPTH(MATRIX_DIM)) i_x2_ram (
        .ap_clk (ap_clk), .rst (rst),
        .we     (load_ok && (load_sel == SEL_X2)),
        .waddr  (load_addr[VEC_AW-1:0]), .wdata (load_data),
        .en     (x2_en), .addr (x2_addr), .dout (x2_dout)
    );

    kernel_ram #(.DEPTH(MATRIX_DIM)) i_y1_ram (
        .ap_clk (ap_clk), .rst (rst),
        .we     (load_ok && (load_sel == SEL_Y1)),
        .waddr  (load_addr[VEC_AW-1:0]), .wdata (load_data),
        .en     (y1_en), .addr (y1_addr), .dout (y1_dout)
    );

    kernel_ram #(.DEPTH(MATRIX_DIM)) i_y2_ram (
        .ap_clk (ap_clk), .rst (rst),
        .we     (load_ok && (load_sel == SEL_Y2)),
        .waddr  (load_addr[VEC_AW-1:0]), .wdata (load_data),
        .en     (y2_en), .addr (y2_addr), .dout (y2_dout)
    );

    // ####################################################################
    // kernel and output fold
    // ####################################################################

    mvt_core #(
        .MATRIX_DIM       (MATRIX_DIM),
        .PARTITION_FACTOR (PARTITION_FACTOR)
    ) i_core (
        .ap_clk   (ap_clk),   .rst      (rst),
        .ap_start (ap_start), .ap_done  (ap_done),  .ap_idle (ap_idle),
        .a_en     (a_en),     .a_addr   (a_addr),   .a_dout  (a_dout),
        .x1_en    (x1_en),    .x1_addr  (x1_addr),  .x1_dout (x1_dout),
        .x2_en    (x2_en),    .x2_addr  (x2_addr),  .x2_dout (x2_dout),
        .y1_en    (y1_en),    .y1_addr  (y1_addr),  .y1_dout (y1_dout),
        .y2_en    (y2_en),    .y2_addr  (y2_addr),  .y2_dout (y2_dout),
        .res      (res_if.producer)
    );

    xor_fold i_fold (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .res        (res_if.consumer),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

`default_nettype wire

//--- mvt_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mvt_checker
    import mvt_pkg::*;
#(
    parameter int MATRIX_DIM = 4
)
(
    input  logic              ap_clk,
    input  logic              rst,
    input  logic              ap_done,
    input  logic              ap_idle,
    input  logic [FOLD_W-1:0] data_out,
    input  logic              data_valid,
    output int                tests_done,
    output int                tests_passed,
    output int                tests_failed,
    output int                error_count
);

    // expected signatures in output order
    logic [FOLD_W-1:0] exp_q [$];
    logic              rst_q;
    logic              done_seen;
    int                test_num;
    int                nibble_idx;
    int                test_errors;

    // signature model: xor the four bytes, then the two nibbles
    function automatic logic [FOLD_W-1:0] fold_word(input word_t w);
        logic [7:0] b;
        b = w[31:24] ^ w[23:16] ^ w[15:8] ^ w[7:0];
        return b[7:4] ^ b[3:0];
    endfunction

    task automatic add_expected(input word_t w);
        exp_q.push_back(fold_word(w));
    endtask

    // ####################################################################
    // output monitor
    // ####################################################################

    always @(posedge ap_clk)
    begin : watch
        int                errs;
        logic [FOLD_W-1:0] exp_nib;
        errs = 0;
        rst_q <= rst;
        if (rst)
        begin
            exp_q.delete();
            done_seen    = 1'b0;
            test_num     = 0;
            nibble_idx   = 0;
            test_errors  = 0;
            tests_done   <= 0;
            tests_passed <= 0;
            tests_failed <= 0;
            error_count  <= 0;
        end
        else
        begin
            // first cycle out of reset
            if (rst_q && (!ap_idle || ap_done))
            begin
                $display("time %0t: DUT is not idle right after reset", $time);
                errs++;
            end
            if (ap_done)
            begin
                if (done_seen)
                begin
                    $display("time %0t: ap_done pulsed twice in test %0d", $time, test_num);
                    errs++;
                end
                done_seen = 1'b1;
            end
            if (data_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("time %0t: data_valid with no result expected", $time);
                    errs++;
                end
                else
                begin
                    exp_nib = exp_q.pop_front();
                    if (data_out !== exp_nib)
                    begin
                        $display("FAIL time %0t test %0d index %0d expected %h got %h",
                                 $time, test_num, nibble_idx, exp_nib, data_out);
                        errs++;
                    end
                    nibble_idx++;
                end
            end
            // run closes once done was seen and every signature came out
            if (done_seen && exp_q.size() == 0)
            begin
                if (nibble_idx != 2 * MATRIX_DIM)
                begin
                    $display("test %0d produced %0d results instead of %0d",
                             test_num, nibble_idx, 2 * MATRIX_DIM);
                    errs++;
                end
                if (!ap_idle)
                begin
                    $display("time %0t: DUT did not return to idle after test %0d",
                             $time, test_num);
                    errs++;
                end
                test_errors = test_errors + errs;
                $display("test %0d: %0d signatures checked, %0d errors, %s",
                         test_num, nibble_idx, test_errors, (test_errors == 0) ? "ok" : "bad");
                if (test_errors == 0)
                begin
                    tests_passed <= tests_passed + 1;
                end
                else
                begin
                    tests_failed <= tests_failed + 1;
                end
                test_num    = test_num + 1;
                tests_done  <= test_num;
                done_seen   = 1'b0;
                nibble_idx  = 0;
                test_errors = 0;
            end
            else
            begin
                test_errors = test_errors + errs;
            end
            error_count <= error_count + errs;
        end
    end

endmodule

`default_nettype wire

//--- tb_mvt.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mvt
    import mvt_pkg::*;
();

    localparam int N              = 4;
    localparam int PF             = 2;
    localparam int BANK_DEPTH     = N * N / PF;
    localparam int BANK_AW        = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
    localparam int NUM_TESTS      = 3;
    localparam int WORDS_PER_TEST = N * N + 6 * N;
    localparam int RST_CYCLES     = 3;
    localparam int unsigned SEED  = 32'hba72;
    // each load takes at most four cycles with its gap
    localparam int LOAD_CYCLES    = 4 * (N * N + 4 * N) + 8;
    localparam int CYCLE_LIMIT    = RST_CYCLES
                                  + NUM_TESTS * (LOAD_CYCLES + 2 * N * (N + 2) + 20);

    logic                 ap_clk;
    logic                 rst;
    logic                 ap_start;
    logic                 ap_done;
    logic                 ap_idle;
    logic                 load_we;
    logic [MEM_SEL_W-1:0] load_sel;
    logic [BANK_AW-1:0]   load_addr;
    word_t                load_data;
    logic [FOLD_W-1:0]    data_out;
    logic                 data_valid;

    // per test: A row-major, x1, x2, y1, y2, expected x1_out, expected x2_out
    word_t       test_mem [NUM_TESTS * WORDS_PER_TEST];
    int          cycle_cnt = 0;
    int          tests_done;
    int          tests_passed;
    int          tests_failed;
    int          error_count;
    int unsigned seed_val;

    mvt_top #(
        .MATRIX_DIM       (N),
        .PARTITION_FACTOR (PF)
    ) i_dut (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .ap_start   (ap_start),
        .ap_done    (ap_done),
        .ap_idle    (ap_idle),
        .load_we    (load_we),
        .load_sel   (load_sel),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    mvt_checker #(.MATRIX_DIM(N)) i_chk (
        .ap_clk       (ap_clk),
        .rst          (rst),
        .ap_done      (ap_done),
        .ap_idle      (ap_idle),
        .data_out     (data_out),
        .data_valid   (data_valid),
        .tests_done   (tests_done),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed),
        .error_count  (error_count)
    );

    initial
    begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // ####################################################################
    // watchdog
    // ####################################################################

    always @(posedge ap_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("DUT stopped producing results, run ended after %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ####################################################################
    // stimulus tasks
    // ####################################################################

    task automatic idle_gap();
        repeat ($urandom % 4)
        begin
            @(posedge ap_clk);
            load_we <= 1'b0;
        end
    endtask

    task automatic load_word(input logic [MEM_SEL_W-1:0] sel, input int addr, input word_t data);
        idle_gap();
        @(posedge ap_clk);
        load_we   <= 1'b1;
        load_sel  <= sel;
        load_addr <= BANK_AW'(addr);
        load_data <= data;
    endtask

    task automatic load_test(input int t);
        int base;
        int r;
        int c;
        base = t * WORDS_PER_TEST;
        // row r goes to bank r mod PF
        for (r = 0; r < N; r++)
        begin
            for (c = 0; c < N; c++)
            begin
                load_word(MEM_SEL_W'(r % PF), (r / PF) * N + c, test_mem[base + r * N + c]);
            end
        end
        for (c = 0; c < N; c++)
        begin
            load_word(SEL_X1, c, test_mem[base + N * N + c]);
            load_word(SEL_X2, c, test_mem[base + N * N + N + c]);
            load_word(SEL_Y1, c, test_mem[base + N * N + 2 * N + c]);
            load_word(SEL_Y2, c, test_mem[base + N * N + 3 * N + c]);
        end
        @(posedge ap_clk);
        load_we <= 1'b0;
    endtask

    task automatic start_run(input int t);
        int base;
        int k;
        base = t * WORDS_PER_TEST + N * N + 4 * N;
        idle_gap();
        @(posedge ap_clk);
        ap_start <= 1'b1;
        // x1 results first, then x2
        for (k = 0; k < 2 * N; k++)
        begin
            i_chk.add_expected(test_mem[base + k]);
        end
        @(posedge ap_clk);
        ap_start <= 1'b0;
        // a second start in mid run must be ignored
        repeat (5) @(posedge ap_clk);
        ap_start <= 1'b1;
        @(posedge ap_clk);
        ap_start <= 1'b0;
    endtask

    // ####################################################################
    // main sequence
    // ####################################################################

    initial
    begin
        int t;
        seed_val  = $urandom(SEED);
        rst       = 1'b1;
        ap_start  = 1'b0;
        load_we   = 1'b0;
        load_sel  = '0;
        load_addr = '0;
        load_data = '0;
        $readmemh("mvt_tests.txt", test_mem);

        repeat (RST_CYCLES) @(posedge ap_clk);
        rst <= 1'b0;
        repeat (4) @(posedge ap_clk);

        for (t = 0; t < NUM_TESTS; t++)
        begin
            load_test(t);
            start_run(t);
            wait (tests_done == t + 1);
            @(posedge ap_clk);
        end

        repeat (8) @(posedge ap_clk);
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_passed == NUM_TESTS)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mvt_bench.f
mvt_pkg.sv
mvt_out_if.sv
kernel_ram.sv
mvt_core.sv
xor_fold.sv
mvt_top.sv
mvt_checker.sv
tb_mvt.sv

//--- mvt_tests.txt
// 40 hex words per test, four per line: A rows 0 to 3, then x1, x2, y1, y2,
// then expected x1_out and expected x2_out
// test 0: small values
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000009 0000000a 0000000b 0000000c
0000000d 0000000e 0000000f 00000010
00000001 00000002 00000003 00000004
0000000a 00000014 0000001e 00000028
00000001 00000002 00000003 00000004
00000004 00000003 00000002 00000001
0000001f 00000048 00000071 0000009a
0000003c 00000050 00000064 00000078
// test 1: large values that wrap modulo 2^32
ffffffff fffffffe fffffffd fffffffc
fffffffb fffffffa fffffff9 fffffff8
fffffff7 fffffff6 fffffff5 fffffff4
fffffff3 fffffff2 fffffff1 fffffff0
fffffff0 80000010 deadbeef 00000100
00000010 80000008 12345678 0000001c
80000000 00000001 00000002 ffffffff
00000003 fffffffe 40000000 00000001
7fffffec 00000004 5eadbedb 800000e4
c000000a 00000000 5234566e 00000010
// test 2: identity A with x at zero
00000001 00000000 00000000 00000000
00000000 00000001 00000000 00000000
00000000 00000000 00000001 00000000
00000000 00000000 00000000 00000001
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
11223344 a5a5a5a5 0f0f0001 cafef00d
01020304 80000001 76543210 ffff0000
11223344 a5a5a5a5 0f0f0001 cafef00d
01020304 80000001 76543210 ffff0000
